/* hw/a2_glue_pkg.sv */
/*
 * A2 card glue shared definitions
 * Bus, audio and card response types used between the slot logic
 * and the card functions, plus the speaker page decode and the
 * shifts that place each source in the audio mix.
 */

`default_nettype none

package a2_glue_pkg;

    // Apple II bus widths
    typedef logic [15:0] a2_addr_t;
    typedef logic [7:0]  a2_data_t;

    // Audio widths
    typedef logic [15:0] audio_sample_t;
    typedef logic [9:0]  mb_audio_t;

    // One captured bus cycle, 25 bits
    typedef struct packed {
        a2_addr_t addr;
        a2_data_t data;
        logic     rw_n;
    } bus_cycle_t;

    // Response of one card, 10 bits
    typedef struct packed {
        logic     rd_en;
        a2_data_t data;
        logic     irq_n;
    } card_resp_t;

    // Upper 12 address bits of the speaker soft switch range C030-C03F
    localparam logic [11:0] SPEAKER_PAGE = 12'hC03;

    // Placement of the sources in the 16 bit mix
    localparam int MB_AUDIO_SHIFT = 5;
    localparam int SPEAKER_SHIFT  = 13;

endpackage

`default_nettype wire

/* hw/por_heartbeat.sv */
/*
 * Power-on reset release and heartbeat
 * A half-period counter toggles the heartbeat LED on every wrap.
 * The first wrap releases the internal reset and it stays released
 * until the next external reset.
 */

`default_nettype none

module por_heartbeat #(
    parameter int HALF_PERIOD_CYCLES = 10_000_000
) (
    input  wire  clk_logic_w,
    input  wire  reset_i,
    output logic heartbeat_o,
    output logic por_done_o
);

    localparam int CNT_W = (HALF_PERIOD_CYCLES > 1) ? $clog2(HALF_PERIOD_CYCLES) : 1;

    logic [CNT_W-1:0] half_cnt_q;
    logic             wrap;

    assign wrap = (half_cnt_q == CNT_W'(HALF_PERIOD_CYCLES - 1));

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            half_cnt_q  <= '0;
            heartbeat_o <= 1'b0;
            por_done_o  <= 1'b0;
        end else begin
            if (wrap) begin
                half_cnt_q  <= '0;
                heartbeat_o <= ~heartbeat_o;
                // Sticky, only reset clears it
                por_done_o  <= 1'b1;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
        end
    end

    // Once released, the internal reset never comes back on its own
    por_done_sticky: assert property (
        @(posedge clk_logic_w) (por_done_o && !reset_i) |=> por_done_o
    );

endmodule

`default_nettype wire

/* hw/bus_cycle_capture.sv */
/*
 * Apple II bus cycle capture
 * Brings phi1 into the logic clock through a two-flop synchronizer
 * and a two-sample agreement filter. On each rising edge of the
 * filtered phi1 the address, data and rw lines are captured and a
 * single-clock strobe marks the new cycle.
 */

`default_nettype none

module bus_cycle_capture (
    input  wire                    clk_logic_w,
    input  wire                    reset_i,
    input  wire                    phi1_i,
    input  wire a2_glue_pkg::a2_addr_t a2_a_i,
    input  wire a2_glue_pkg::a2_data_t a2_d_i,
    input  wire                    a2_rw_n_i,
    output a2_glue_pkg::bus_cycle_t  cycle_o,
    output logic                   cycle_valid_o
);

    // Synchronizer stages
    logic phi1_meta_q;
    logic phi1_sync_q;

    // Previous synchronized sample, for the agreement filter
    logic phi1_prev_q;
    logic phi1_filt_q;

    logic samples_agree;
    logic phi1_rise;

    assign samples_agree = (phi1_sync_q == phi1_prev_q);

    // Filtered level is about to go from low to high
    assign phi1_rise = samples_agree && phi1_sync_q && !phi1_filt_q;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            phi1_meta_q <= 1'b0;
            phi1_sync_q <= 1'b0;
            phi1_prev_q <= 1'b0;
            phi1_filt_q <= 1'b0;
        end else begin
            phi1_meta_q <= phi1_i;
            phi1_sync_q <= phi1_meta_q;
            phi1_prev_q <= phi1_sync_q;
            // A single odd sample is ignored
            if (samples_agree) begin
                phi1_filt_q <= phi1_sync_q;
            end
        end
    end

    // Capture the bus in the same clock the filtered phi1 rises
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            cycle_valid_o <= 1'b0;
            cycle_o       <= '0;
        end else begin
            cycle_valid_o <= phi1_rise;
            if (phi1_rise) begin
                cycle_o.addr <= a2_a_i;
                cycle_o.data <= a2_d_i;
                cycle_o.rw_n <= a2_rw_n_i;
            end
        end
    end

    // A phi1 period is many clocks long, so strobes never run back to back
    cycle_valid_single: assert property (
        @(posedge clk_logic_w) disable iff (reset_i)
        cycle_valid_o |=> !cycle_valid_o
    );

endmodule

`default_nettype wire

/* hw/card_response_mux.sv */
/*
 * Card response selection
 * Picks the read data the cards return to the Apple II by fixed
 * priority (serial, sprite, Mockingboard), drives the data buffer
 * direction and combines the card interrupts onto the slot IRQ.
 */

`default_nettype none

module card_response_mux #(
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1
) (
    input  wire                      reset_i,
    input  wire a2_glue_pkg::card_resp_t ssc_resp_i,
    input  wire a2_glue_pkg::card_resp_t ssp_resp_i,
    input  wire a2_glue_pkg::card_resp_t mb_resp_i,
    input  wire a2_glue_pkg::bus_cycle_t cycle_i,
    output a2_glue_pkg::a2_data_t      a2_d_o,
    output logic                     a2_d_dir_o,
    output logic                     a2_irq_n_o
);

    logic any_rd_en;
    logic irq_n_all;

    assign any_rd_en = ssc_resp_i.rd_en || ssp_resp_i.rd_en || mb_resp_i.rd_en;
    assign irq_n_all = ssc_resp_i.irq_n && ssp_resp_i.irq_n && mb_resp_i.irq_n;

    // Fixed priority, falls back to the last captured bus data
    always_comb begin
        if (ssc_resp_i.rd_en) begin
            a2_d_o = ssc_resp_i.data;
        end else if (ssp_resp_i.rd_en) begin
            a2_d_o = ssp_resp_i.data;
        end else if (mb_resp_i.rd_en) begin
            a2_d_o = mb_resp_i.data;
        end else begin
            a2_d_o = cycle_i.data;
        end
    end

    // 1 = FPGA drives the Apple II data bus
    assign a2_d_dir_o = any_rd_en && BUS_DATA_OUT_ENABLE && !reset_i;

    // Open-collector style wired AND of the card interrupts
    assign a2_irq_n_o = (IRQ_OUT_ENABLE && !reset_i) ? irq_n_all : 1'b1;

endmodule

`default_nettype wire

/* hw/audio_mixer.sv */
/*
 * Speaker toggle and audio mix
 * Any access to C030-C03F flips the Apple II speaker bit. The
 * sprite card audio, the shifted Mockingboard channels and the
 * speaker bit are summed into registered 16 bit left and right
 * samples that wrap on overflow.
 */

`default_nettype none

module audio_mixer #(
    parameter bit SPEAKER_ENABLE = 1'b1
) (
    input  wire                         clk_logic_w,
    input  wire                         reset_i,
    input  wire a2_glue_pkg::bus_cycle_t    cycle_i,
    input  wire                         cycle_valid_i,
    input  wire a2_glue_pkg::audio_sample_t ssp_audio_i,
    input  wire a2_glue_pkg::mb_audio_t     mb_audio_l_i,
    input  wire a2_glue_pkg::mb_audio_t     mb_audio_r_i,
    output a2_glue_pkg::audio_sample_t    audio_l_o,
    output a2_glue_pkg::audio_sample_t    audio_r_o
);

    import a2_glue_pkg::*;

    logic          speaker_q;
    logic          speaker_hit;
    audio_sample_t mix_l;
    audio_sample_t mix_r;

    // Sum of one channel, modulo 2^16
    function automatic audio_sample_t mix_channel(
        input audio_sample_t ssp,
        input mb_audio_t     mb,
        input logic          spk
    );
        audio_sample_t mb_term;
        audio_sample_t spk_term;
        mb_term  = audio_sample_t'(mb) << MB_AUDIO_SHIFT;
        spk_term = audio_sample_t'(spk) << SPEAKER_SHIFT;
        return ssp + mb_term + spk_term;
    endfunction

    // Reads and writes both count, as on the real machine
    assign speaker_hit = cycle_valid_i && (cycle_i.addr[15:4] == SPEAKER_PAGE);

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            speaker_q <= 1'b0;
        end else if (speaker_hit && SPEAKER_ENABLE) begin
            speaker_q <= ~speaker_q;
        end
    end

    assign mix_l = mix_channel(ssp_audio_i, mb_audio_l_i, speaker_q);
    assign mix_r = mix_channel(ssp_audio_i, mb_audio_r_i, speaker_q);

    // One clock of latency from the sources
    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_l;
            audio_r_o <= mix_r;
        end
    end

endmodule

`default_nettype wire

/* hw/a2_card_glue.sv */
/*
 * A2 card glue top level
 * Sits between the Apple II slot and the card functions. Builds the
 * system reset from the external reset, the slot reset and the
 * power-on release, captures bus cycles and feeds them to the card
 * response selection and to the audio mixer.
 */

`default_nettype none

module a2_card_glue #(
    parameter int HALF_PERIOD_CYCLES  = 10_000_000,
    parameter bit SPEAKER_ENABLE      = 1'b1,
    parameter bit IRQ_OUT_ENABLE      = 1'b1,
    parameter bit BUS_DATA_OUT_ENABLE = 1'b1
) (
    input  wire                         clk_logic_w,
    input  wire                         reset_i,
    input  wire                         a2_reset_n_i,

    // Apple II bus
    input  wire                         phi1_i,
    input  wire a2_glue_pkg::a2_addr_t      a2_a_i,
    input  wire a2_glue_pkg::a2_data_t      a2_d_i,
    input  wire                         a2_rw_n_i,

    // Card responses
    input  wire a2_glue_pkg::card_resp_t    ssc_resp_i,
    input  wire a2_glue_pkg::card_resp_t    ssp_resp_i,
    input  wire a2_glue_pkg::card_resp_t    mb_resp_i,

    // Card audio
    input  wire a2_glue_pkg::audio_sample_t ssp_audio_i,
    input  wire a2_glue_pkg::mb_audio_t     mb_audio_l_i,
    input  wire a2_glue_pkg::mb_audio_t     mb_audio_r_i,

    output a2_glue_pkg::a2_data_t         a2_d_o,
    output logic                        a2_d_dir_o,
    output logic                        a2_irq_n_o,
    output a2_glue_pkg::audio_sample_t    audio_l_o,
    output a2_glue_pkg::audio_sample_t    audio_r_o,
    output logic                        heartbeat_o
);

    import a2_glue_pkg::*;

    logic       por_done;
    logic       sys_reset;
    bus_cycle_t cycle;
    logic       cycle_valid;

    por_heartbeat #(
        .HALF_PERIOD_CYCLES(HALF_PERIOD_CYCLES)
    ) u_por_heartbeat (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .heartbeat_o (heartbeat_o),
        .por_done_o  (por_done)
    );

    // Everything past the heartbeat waits for power-on release and the slot reset
    assign sys_reset = reset_i || !a2_reset_n_i || !por_done;

    bus_cycle_capture u_bus_cycle_capture (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (sys_reset),
        .phi1_i        (phi1_i),
        .a2_a_i        (a2_a_i),
        .a2_d_i        (a2_d_i),
        .a2_rw_n_i     (a2_rw_n_i),
        .cycle_o       (cycle),
        .cycle_valid_o (cycle_valid)
    );

    card_response_mux #(
        .BUS_DATA_OUT_ENABLE(BUS_DATA_OUT_ENABLE),
        .IRQ_OUT_ENABLE     (IRQ_OUT_ENABLE)
    ) u_card_response_mux (
        .reset_i    (sys_reset),
        .ssc_resp_i (ssc_resp_i),
        .ssp_resp_i (ssp_resp_i),
        .mb_resp_i  (mb_resp_i),
        .cycle_i    (cycle),
        .a2_d_o     (a2_d_o),
        .a2_d_dir_o (a2_d_dir_o),
        .a2_irq_n_o (a2_irq_n_o)
    );

    audio_mixer #(
        .SPEAKER_ENABLE(SPEAKER_ENABLE)
    ) u_audio_mixer (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (sys_reset),
        .cycle_i       (cycle),
        .cycle_valid_i (cycle_valid),
        .ssp_audio_i   (ssp_audio_i),
        .mb_audio_l_i  (mb_audio_l_i),
        .mb_audio_r_i  (mb_audio_r_i),
        .audio_l_o     (audio_l_o),
        .audio_r_o     (audio_r_o)
    );

endmodule

`default_nettype wire

/* sim/tb_a2_card_glue.sv */
/*
 * Directed testbench for the A2 card glue
 * Drives the slot bus, card responses and card audio, and checks
 * reset release, heartbeat, read data priority, interrupts, bus data
 * fallback, the speaker toggle and the audio mix.
 */

`default_nettype none

module tb_a2_card_glue;

    timeunit 1ns;
    timeprecision 100ps;

    import a2_glue_pkg::*;

    localparam int HALF_PERIOD  = 64;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 1;
    localparam int PHI1_LEVEL   = 10;
    localparam int TIMEOUT      = 300;

    logic          clk_logic_w;
    logic          reset_i;
    logic          a2_reset_n_i;
    logic          phi1_i;
    a2_addr_t      a2_a_i;
    a2_data_t      a2_d_i;
    logic          a2_rw_n_i;
    card_resp_t    ssc_resp_i;
    card_resp_t    ssp_resp_i;
    card_resp_t    mb_resp_i;
    audio_sample_t ssp_audio_i;
    mb_audio_t     mb_audio_l_i;
    mb_audio_t     mb_audio_r_i;
    a2_data_t      a2_d_o;
    logic          a2_d_dir_o;
    logic          a2_irq_n_o;
    audio_sample_t audio_l_o;
    audio_sample_t audio_r_o;
    logic          heartbeat_o;

    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [31:0] rng_state   = 32'h4f85;
    // Model state: data of the last bus cycle and the speaker level
    a2_data_t    last_bus_data = '0;
    logic        speaker_exp   = 1'b0;

    a2_card_glue #(
        .HALF_PERIOD_CYCLES(HALF_PERIOD)
    ) uut (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .a2_reset_n_i (a2_reset_n_i),
        .phi1_i       (phi1_i),
        .a2_a_i       (a2_a_i),
        .a2_d_i       (a2_d_i),
        .a2_rw_n_i    (a2_rw_n_i),
        .ssc_resp_i   (ssc_resp_i),
        .ssp_resp_i   (ssp_resp_i),
        .mb_resp_i    (mb_resp_i),
        .ssp_audio_i  (ssp_audio_i),
        .mb_audio_l_i (mb_audio_l_i),
        .mb_audio_r_i (mb_audio_r_i),
        .a2_d_o       (a2_d_o),
        .a2_d_dir_o   (a2_d_dir_o),
        .a2_irq_n_o   (a2_irq_n_o),
        .audio_l_o    (audio_l_o),
        .audio_r_o    (audio_r_o),
        .heartbeat_o  (heartbeat_o)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #20 clk_logic_w = ~clk_logic_w;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic card_resp_t make_resp(input logic rd_en, input a2_data_t data,
                                             input logic irq_n);
        card_resp_t resp;
        resp.rd_en = rd_en;
        resp.data  = data;
        resp.irq_n = irq_n;
        return resp;
    endfunction

    // sel[0] is the serial card, sel[1] the sprite card, sel[2] the Mockingboard
    function automatic a2_data_t expected_read_data(input logic [2:0] sel,
            input a2_data_t ssc_data, input a2_data_t ssp_data,
            input a2_data_t mb_data, input a2_data_t bus_data);
        a2_data_t result;
        result = bus_data;
        if (sel[2]) result = mb_data;
        if (sel[1]) result = ssp_data;
        if (sel[0]) result = ssc_data;
        return result;
    endfunction

    // Shifts by 5 and 13 written as products, wrapped to 16 bits
    function automatic audio_sample_t expected_mix(input audio_sample_t ssp,
                                                   input mb_audio_t mb, input logic spk);
        logic [31:0] sum;
        sum = 32'(ssp) + 32'(mb) * 32 + 32'(spk) * 32'h2000;
        return sum[15:0];
    endfunction

    task automatic compare_data(input string name, input a2_data_t got, input a2_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_audio(input string name, input audio_sample_t got,
                                 input audio_sample_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic timeout_failure(input string what);
        error_count++;
        $display("Timeout at %0d ns: %s", $time, what);
    endtask

    task automatic report_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_count, name, error_count - start_errors);
        end
    endtask

    task automatic drive_point();
        @(posedge clk_logic_w);
        #DRIVE_DELAY;
    endtask

    task automatic sample_point();
        @(posedge clk_logic_w);
        #SAMPLE_DELAY;
    endtask

    // One slow phi1 period with the bus lines held throughout
    task automatic bus_cycle(input a2_addr_t addr, input a2_data_t data, input logic rw_n);
        drive_point();
        a2_a_i    = addr;
        a2_d_i    = data;
        a2_rw_n_i = rw_n;
        phi1_i    = 1'b0;
        repeat (PHI1_LEVEL) @(posedge clk_logic_w);
        #DRIVE_DELAY;
        phi1_i = 1'b1;
        repeat (PHI1_LEVEL) @(posedge clk_logic_w);
        #DRIVE_DELAY;
        phi1_i = 1'b0;
        repeat (PHI1_LEVEL) @(posedge clk_logic_w);
        #SAMPLE_DELAY;
        last_bus_data = data;
        if (addr[15:4] == 12'hC03) speaker_exp = ~speaker_exp;
    endtask

    // Number of clocks until heartbeat_o leaves its current level
    task automatic measure_heartbeat(output int cycles, output bit seen);
        logic level;
        level  = heartbeat_o;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            sample_point();
            cycles++;
            if (heartbeat_o !== level) seen = 1'b1;
        end
    endtask

    task automatic test_reset_release();
        int start_errors;
        int cycles;
        bit seen;
        start_errors = error_count;
        drive_point();
        ssc_resp_i = make_resp(1'b1, 8'h5A, 1'b0);
        ssp_resp_i = make_resp(1'b1, 8'hA5, 1'b0);
        mb_resp_i  = make_resp(1'b1, 8'h3C, 1'b0);
        cycles = 0;
        seen   = 1'b0;
        // Bus buffer and IRQ stay off until the first heartbeat edge
        while (!seen && cycles < TIMEOUT) begin
            sample_point();
            cycles++;
            if (heartbeat_o === 1'b1) begin
                seen = 1'b1;
            end else begin
                compare_bit("a2_d_dir_o", a2_d_dir_o, 1'b0);
                compare_bit("a2_irq_n_o", a2_irq_n_o, 1'b1);
            end
        end
        if (!seen) begin
            timeout_failure("heartbeat_o never rose after reset");
        end else begin
            repeat (2) begin
                measure_heartbeat(cycles, seen);
                if (!seen) timeout_failure("heartbeat_o stopped toggling");
                else compare_count("heartbeat half period", cycles, HALF_PERIOD);
            end
        end
        drive_point();
        ssc_resp_i = make_resp(1'b0, 8'h00, 1'b1);
        ssp_resp_i = make_resp(1'b0, 8'h00, 1'b1);
        mb_resp_i  = make_resp(1'b0, 8'h00, 1'b1);
        report_test("reset release and heartbeat", start_errors);
    endtask

    task automatic test_read_priority();
        int          start_errors;
        logic [2:0]  sel;
        logic [31:0] r;
        start_errors = error_count;
        for (int round = 0; round < 2; round++) begin
            for (int combo = 0; combo < 8; combo++) begin
                sel = 3'(combo);
                r   = next_random();
                drive_point();
                ssc_resp_i = make_resp(sel[0], r[7:0], 1'b1);
                ssp_resp_i = make_resp(sel[1], r[15:8], 1'b1);
                mb_resp_i  = make_resp(sel[2], r[23:16], 1'b1);
                @(negedge clk_logic_w);
                compare_data("a2_d_o", a2_d_o,
                             expected_read_data(sel, r[7:0], r[15:8], r[23:16], last_bus_data));
                compare_bit("a2_d_dir_o", a2_d_dir_o, |sel);
            end
        end
        report_test("read data priority", start_errors);
    endtask

    task automatic test_irq_combine();
        int         start_errors;
        logic [2:0] irq_n;
        start_errors = error_count;
        for (int combo = 0; combo < 8; combo++) begin
            irq_n = 3'(combo);
            drive_point();
            ssc_resp_i = make_resp(1'b0, 8'h00, irq_n[0]);
            ssp_resp_i = make_resp(1'b0, 8'h00, irq_n[1]);
            mb_resp_i  = make_resp(1'b0, 8'h00, irq_n[2]);
            @(negedge clk_logic_w);
            compare_bit("a2_irq_n_o", a2_irq_n_o, irq_n == 3'b111);
            compare_bit("a2_d_dir_o", a2_d_dir_o, 1'b0);
        end
        report_test("interrupt combine", start_errors);
    endtask

    task automatic test_bus_data_fallback();
        int          start_errors;
        logic [31:0] r;
        start_errors = error_count;
        repeat (3) begin
            r = next_random();
            bus_cycle({8'h04, r[7:0]}, r[15:8], 1'b0);
            @(negedge clk_logic_w);
            compare_data("a2_d_o", a2_d_o, r[15:8]);
            compare_bit("a2_d_dir_o", a2_d_dir_o, 1'b0);
        end
        report_test("bus data fallback", start_errors);
    endtask

    task automatic wait_for_audio(input audio_sample_t exp, input string what);
        int cycles;
        cycles = 0;
        while ((audio_l_o !== exp || audio_r_o !== exp) && cycles < TIMEOUT) begin
            sample_point();
            cycles++;
        end
        if (audio_l_o !== exp || audio_r_o !== exp) begin
            timeout_failure(what);
        end else begin
            compare_audio("audio_l_o", audio_l_o, exp);
            compare_audio("audio_r_o", audio_r_o, exp);
        end
    endtask

    task automatic test_speaker_toggle();
        int start_errors;
        start_errors = error_count;
        drive_point();
        ssp_audio_i  = '0;
        mb_audio_l_i = '0;
        mb_audio_r_i = '0;
        wait_for_audio(expected_mix('0, '0, speaker_exp), "audio did not settle to zero");
        bus_cycle(16'hC030, 8'h00, 1'b1);
        wait_for_audio(expected_mix('0, '0, speaker_exp), "speaker did not toggle on C030");
        bus_cycle(16'hC035, 8'h00, 1'b1);
        wait_for_audio(expected_mix('0, '0, speaker_exp), "speaker did not toggle on C035");
        bus_cycle(16'hD000, 8'h00, 1'b1);
        sample_point();
        compare_audio("audio_l_o", audio_l_o, expected_mix('0, '0, speaker_exp));
        report_test("speaker toggle", start_errors);
    endtask

    task automatic test_audio_mix();
        int            start_errors;
        logic [31:0]   r;
        logic [31:0]   s;
        audio_sample_t prev_l;
        audio_sample_t prev_r;
        start_errors = error_count;
        prev_l = expected_mix('0, '0, speaker_exp);
        prev_r = prev_l;
        repeat (20) begin
            r = next_random();
            s = next_random();
            drive_point();
            ssp_audio_i  = r[15:0];
            mb_audio_l_i = r[25:16];
            mb_audio_r_i = s[9:0];
            // Registered outputs still hold the old sum before the next edge
            @(negedge clk_logic_w);
            compare_audio("audio_l_o", audio_l_o, prev_l);
            compare_audio("audio_r_o", audio_r_o, prev_r);
            prev_l = expected_mix(r[15:0], r[25:16], speaker_exp);
            prev_r = expected_mix(r[15:0], s[9:0], speaker_exp);
            sample_point();
            compare_audio("audio_l_o", audio_l_o, prev_l);
            compare_audio("audio_r_o", audio_r_o, prev_r);
        end
        report_test("audio mix", start_errors);
    endtask

    initial begin
        reset_i      = 1'b1;
        a2_reset_n_i = 1'b1;
        phi1_i       = 1'b0;
        a2_a_i       = '0;
        a2_d_i       = '0;
        a2_rw_n_i    = 1'b1;
        ssc_resp_i   = make_resp(1'b0, 8'h00, 1'b1);
        ssp_resp_i   = make_resp(1'b0, 8'h00, 1'b1);
        mb_resp_i    = make_resp(1'b0, 8'h00, 1'b1);
        ssp_audio_i  = '0;
        mb_audio_l_i = '0;
        mb_audio_r_i = '0;
        repeat (10) @(posedge clk_logic_w);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        test_reset_release();
        test_read_priority();
        test_irq_combine();
        test_bus_data_fallback();
        test_speaker_toggle();
        test_audio_mix();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/a2_glue_pkg.sv
hw/por_heartbeat.sv
hw/bus_cycle_capture.sv
hw/card_response_mux.sv
hw/audio_mixer.sv
hw/a2_card_glue.sv
sim/tb_a2_card_glue.sv

/* Makefile */
# Verilator build and run of the A2 card glue testbench

SIM       = verilator
TOP       = tb_a2_card_glue
FILELIST  = sim.f
SIM_FLAGS = --binary --timing --assert -Wno-fatal
BUILD_DIR = obj_dir
PASS_MSG  = TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The pipeline status is the status of grep, so a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
